// File: hw/jsp_pkg.sv
/*
  JTAG serial port shared definitions
  Byte and count widths, bit index limits and the FSM state
  encodings used by the write and read controllers
*/

`default_nettype none

package jsp_pkg;

  ////////////////////////////////
  // Widths and counts
  ////////////////////////////////

  localparam int JSP_BYTE_W    = 8;                   // Serial byte
  localparam int JSP_NIBBLE_W  = 4;                   // Each count field
  localparam int JSP_BIT_MAX   = 7;                   // Index of last bit in a byte
  localparam int JSP_BIT_CNT_W = $clog2(JSP_BYTE_W);  // Bit counter width
  localparam int JSP_DR_W      = 7;                   // Upper data register bits seen by the top

  // Write path waits for a start bit after capture when set
  // Needed when other devices sit in the same JTAG chain
  localparam logic JSP_MULTI_CHAIN = 1'b1;

  ////////////////////////////////
  // FSM states
  ////////////////////////////////

  // Host to bus direction
  typedef enum logic [1:0] {
    WR_IDLE   = 2'h0,  // No scan in progress
    WR_WAIT   = 2'h1,  // Waiting for the start bit
    WR_COUNTS = 2'h2,  // Count frame from host
    WR_XFER   = 2'h3   // Data bytes to bus
  } jsp_wr_state_e;

  // Bus to host direction
  typedef enum logic [1:0] {
    RD_IDLE   = 2'h0,  // No scan in progress
    RD_COUNTS = 2'h1,  // Status byte going out
    RD_RDACK  = 2'h2,  // First bit of a data byte, pop happens here
    RD_XFER   = 2'h3   // Remaining bits of the data byte
  } jsp_rd_state_e;

endpackage

`default_nettype wire

// File: hw/jsp_tap_if.sv
/*
  TAP state bundle for the serial port controllers
  Carries the DR capture, shift and update levels plus
  module select and TDI from the top to both FSMs
*/

`default_nettype none

interface jsp_tap_if;

  logic capture_dr;     // TAP in Capture-DR
  logic shift_dr;       // TAP in Shift-DR
  logic update_dr;      // TAP in Update-DR
  logic module_select;  // This module addressed by the debug unit
  logic tdi;            // Serial data from host

  // Both controllers only observe the TAP
  modport controller (
    input capture_dr,
    input shift_dr,
    input update_dr,
    input module_select,
    input tdi
  );

endinterface

`default_nettype wire

// File: hw/jsp_write_ctrl.sv
/*
  JTAG serial port write controller
  Waits for the start bit, takes the host count frame and then
  hands each complete data byte to the bus side with a strobe,
  limited by host count and bus free space
*/

`default_nettype none

module jsp_write_ctrl
  import jsp_pkg::*;
(
  input  logic                    tck_i,
  input  logic                    rst_i,
  jsp_tap_if.controller           tap,
  input  logic [JSP_DR_W-1:0]     dr_i,        // Previous seven TDI bits
  input  logic [JSP_NIBBLE_W-1:0] bus_free_i,
  output logic [JSP_BYTE_W-1:0]   bus_wdata_o,
  output logic                    bus_wr_strobe_o
);

  jsp_wr_state_e             wr_state;
  jsp_wr_state_e             wr_state_nxt;
  logic [JSP_BIT_CNT_W-1:0]  bit_cnt;     // Bits taken in the current byte
  logic [JSP_NIBBLE_W-1:0]   space_cnt;   // Bus space left for this scan
  logic [JSP_NIBBLE_W-1:0]   host_cnt;    // Bytes the host still intends to send
  logic [JSP_NIBBLE_W-1:0]   host_cnt_in; // Upper nibble of the count frame
  logic                      bit_last;
  logic                      bit_clr;
  logic                      bit_inc;
  logic                      space_ld;
  logic                      host_ld;

  assign bit_last    = (bit_cnt == JSP_BIT_CNT_W'(JSP_BIT_MAX));
  assign host_cnt_in = {tap.tdi, dr_i[JSP_DR_W-1 -: JSP_NIBBLE_W-1]};
  assign bus_wdata_o = {tap.tdi, dr_i};  // Eighth bit still on TDI

  ////////////////////////////////
  // FSM
  ////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
    end
  end

  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      WR_IDLE: begin
        if (tap.capture_dr && tap.module_select) begin
          wr_state_nxt = JSP_MULTI_CHAIN ? WR_WAIT : WR_COUNTS;
        end
      end
      WR_WAIT: begin
        if (tap.update_dr) wr_state_nxt = WR_IDLE;
        else if (tap.shift_dr && tap.tdi) wr_state_nxt = WR_COUNTS;  // Start bit
      end
      WR_COUNTS: begin
        if (tap.update_dr) wr_state_nxt = WR_IDLE;
        else if (tap.shift_dr && bit_last) wr_state_nxt = WR_XFER;
      end
      default: begin  // WR_XFER stays until update
        if (tap.update_dr) wr_state_nxt = WR_IDLE;
      end
    endcase
  end

  // Counter controls and strobe, all zero outside shift cycles
  always_comb begin
    bit_clr         = 1'b0;
    bit_inc         = 1'b0;
    space_ld        = 1'b0;
    host_ld         = 1'b0;
    bus_wr_strobe_o = 1'b0;
    case (wr_state)
      WR_IDLE: begin
        if (wr_state_nxt != WR_IDLE) begin
          bit_clr  = 1'b1;
          space_ld = 1'b1;  // Free space as seen at capture
        end
      end
      WR_COUNTS: begin
        if (tap.shift_dr) begin
          bit_inc = 1'b1;
          bit_clr = bit_last;
          host_ld = bit_last;
        end
      end
      WR_XFER: begin
        if (tap.shift_dr) begin
          bit_inc = 1'b1;
          bit_clr = bit_last;
          // Byte complete, pass it on if both counts allow
          bus_wr_strobe_o = bit_last && (space_cnt != '0) && (host_cnt != '0);
        end
      end
      default: ;  // WR_WAIT holds everything
    endcase
  end

  ////////////////////////////////
  // Counters
  ////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt   <= '0;
      space_cnt <= '0;
      host_cnt  <= '0;
    end else begin
      if (bit_clr) bit_cnt <= '0;
      else if (bit_inc) bit_cnt <= bit_cnt + JSP_BIT_CNT_W'(1);

      if (space_ld) space_cnt <= bus_free_i;
      else if (bus_wr_strobe_o) space_cnt <= space_cnt - JSP_NIBBLE_W'(1);

      if (host_ld) host_cnt <= host_cnt_in;
      else if (bus_wr_strobe_o) host_cnt <= host_cnt - JSP_NIBBLE_W'(1);
    end
  end

  // Strobe only on a real shift, and it always closes a byte
  a_wr_strobe_shift: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_wr_strobe_o |-> tap.shift_dr ##1 (bit_cnt == '0));

  a_wr_state_known: assert property (@(posedge tck_i) disable iff (rst_i)
    !$isunknown(wr_state));

endmodule

`default_nettype wire

// File: hw/jsp_read_ctrl.sv
/*
  JTAG serial port read controller
  Shifts out the status byte after capture, then streams the
  bytes waiting on the bus side LSB first, popping each one
  during its first bit
*/

`default_nettype none

module jsp_read_ctrl
  import jsp_pkg::*;
(
  input  logic                    tck_i,
  input  logic                    rst_i,
  jsp_tap_if.controller           tap,
  input  logic [JSP_BYTE_W-1:0]   bus_rdata_i,   // Head of the bus to host queue
  input  logic [JSP_NIBBLE_W-1:0] bus_avail_i,
  input  logic [JSP_NIBBLE_W-1:0] bus_free_i,
  output logic                    bus_rd_strobe_o,
  output logic                    tdo_o
);

  jsp_rd_state_e             rd_state;
  jsp_rd_state_e             rd_state_nxt;
  logic [JSP_BIT_CNT_W-1:0]  bit_cnt;     // Bits sent of the current byte
  logic [JSP_NIBBLE_W-1:0]   avail_cnt;   // Bytes left to send this scan
  logic [JSP_BYTE_W-1:0]     tdo_sreg;    // Parallel load, shift right
  logic                      bit_last;
  logic                      avail_nz;
  logic                      bit_clr;
  logic                      bit_inc;
  logic                      avail_ld;
  logic                      avail_dec;
  logic                      ld_status;
  logic                      ld_data;
  logic                      shift_en;

  assign bit_last = (bit_cnt == JSP_BIT_CNT_W'(JSP_BIT_MAX));
  assign avail_nz = (avail_cnt != '0);
  assign tdo_o    = tdo_sreg[0];

  ////////////////////////////////
  // FSM
  ////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

  // No start bit on this side, data leaves right after capture
  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      RD_IDLE: begin
        if (tap.capture_dr && tap.module_select) rd_state_nxt = RD_COUNTS;
      end
      RD_COUNTS: begin
        if (tap.update_dr) rd_state_nxt = RD_IDLE;
        else if (tap.shift_dr && bit_last) rd_state_nxt = RD_RDACK;
      end
      RD_RDACK: begin
        if (tap.update_dr) rd_state_nxt = RD_IDLE;
        else if (tap.shift_dr) rd_state_nxt = RD_XFER;
      end
      default: begin  // RD_XFER
        if (tap.update_dr) rd_state_nxt = RD_IDLE;
        else if (tap.shift_dr && bit_last) rd_state_nxt = RD_RDACK;
      end
    endcase
  end

  always_comb begin
    bit_clr         = 1'b0;
    bit_inc         = 1'b0;
    avail_ld        = 1'b0;
    avail_dec       = 1'b0;
    ld_status       = 1'b0;
    ld_data         = 1'b0;
    shift_en        = 1'b0;
    bus_rd_strobe_o = 1'b0;
    case (rd_state)
      RD_IDLE: begin
        if (rd_state_nxt != RD_IDLE) begin
          bit_clr   = 1'b1;
          avail_ld  = 1'b1;
          ld_status = 1'b1;  // Avail and free as seen at capture
        end
      end
      RD_COUNTS: begin
        if (tap.shift_dr) begin
          bit_inc  = 1'b1;
          bit_clr  = bit_last;
          ld_data  = bit_last && avail_nz;  // First byte, popped in RD_RDACK
          shift_en = !ld_data;
        end
      end
      RD_RDACK: begin
        if (tap.shift_dr) begin
          bit_inc         = 1'b1;
          shift_en        = 1'b1;
          bus_rd_strobe_o = avail_nz;  // Byte now held in tdo_sreg
        end
      end
      default: begin  // RD_XFER
        if (tap.shift_dr) begin
          bit_inc   = 1'b1;
          bit_clr   = bit_last;
          ld_data   = bit_last && avail_nz;
          avail_dec = ld_data;
          shift_en  = !ld_data;
        end
      end
    endcase
  end

  ////////////////////////////////
  // Counters and shift register
  ////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt   <= '0;
      avail_cnt <= '0;
    end else begin
      if (bit_clr) bit_cnt <= '0;
      else if (bit_inc) bit_cnt <= bit_cnt + JSP_BIT_CNT_W'(1);

      if (avail_ld) avail_cnt <= bus_avail_i;
      else if (avail_dec) avail_cnt <= avail_cnt - JSP_NIBBLE_W'(1);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      tdo_sreg <= '0;
    end else if (ld_status) begin
      tdo_sreg <= {bus_avail_i, bus_free_i};  // Status byte
    end else if (ld_data) begin
      tdo_sreg <= bus_rdata_i;
    end else if (shift_en) begin
      tdo_sreg <= {1'b0, tdo_sreg[JSP_BYTE_W-1:1]};  // LSB first
    end
  end

  // Pop only on the first bit of a byte, never twice in a row
  a_rd_strobe_ack: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_rd_strobe_o |-> ((rd_state == RD_RDACK) && tap.shift_dr)
      ##1 (rd_state != RD_RDACK));

endmodule

`default_nettype wire

// File: hw/jsp_top.sv
/*
  JTAG serial port data path top
  Puts the TAP levels on a shared bundle and runs the write
  and read controllers side by side on TCK
*/

`default_nettype none

module jsp_top
  import jsp_pkg::*;
(
  input  logic                    tck_i,
  input  logic                    rst_i,

  // TAP state and serial data
  input  logic                    capture_dr_i,
  input  logic                    shift_dr_i,
  input  logic                    update_dr_i,
  input  logic                    module_select_i,
  input  logic                    tdi_i,
  input  logic [JSP_DR_W-1:0]     data_register_i,  // Upper DR bits
  output logic                    module_tdo_o,

  // Bus side
  input  logic [JSP_BYTE_W-1:0]   bus_rdata_i,
  input  logic [JSP_NIBBLE_W-1:0] bus_avail_i,
  input  logic [JSP_NIBBLE_W-1:0] bus_free_i,
  output logic [JSP_BYTE_W-1:0]   bus_wdata_o,
  output logic                    bus_wr_strobe_o,
  output logic                    bus_rd_strobe_o
);

  jsp_tap_if u_tap ();

  // TAP levels shared by both directions
  assign u_tap.capture_dr    = capture_dr_i;
  assign u_tap.shift_dr      = shift_dr_i;
  assign u_tap.update_dr     = update_dr_i;
  assign u_tap.module_select = module_select_i;
  assign u_tap.tdi           = tdi_i;

  // Host to bus
  jsp_write_ctrl u_write_ctrl (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tap             (u_tap),
    .dr_i            (data_register_i),
    .bus_free_i      (bus_free_i),
    .bus_wdata_o     (bus_wdata_o),
    .bus_wr_strobe_o (bus_wr_strobe_o)
  );

  // Bus to host
  jsp_read_ctrl u_read_ctrl (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tap             (u_tap),
    .bus_rdata_i     (bus_rdata_i),
    .bus_avail_i     (bus_avail_i),
    .bus_free_i      (bus_free_i),
    .bus_rd_strobe_o (bus_rd_strobe_o),
    .tdo_o           (module_tdo_o)
  );

endmodule

`default_nettype wire

// File: testbench/jsp_checker.sv
/*
  JTAG serial port checker
  Follows both scan directions from the DUT ports, predicts the
  TDO bits and the bus strobes, and counts the mismatches
*/

`default_nettype none

module jsp_checker
  import jsp_pkg::*;
(
  input  logic                    tck_i,
  input  logic                    rst_i,
  input  logic                    capture_dr_i,
  input  logic                    shift_dr_i,
  input  logic                    update_dr_i,
  input  logic                    module_select_i,
  input  logic                    tdi_i,
  input  logic [JSP_BYTE_W-1:0]   bus_rdata_i,
  input  logic [JSP_NIBBLE_W-1:0] bus_avail_i,
  input  logic [JSP_NIBBLE_W-1:0] bus_free_i,
  input  logic                    module_tdo_i,
  input  logic [JSP_BYTE_W-1:0]   bus_wdata_i,
  input  logic                    bus_wr_strobe_i,
  input  logic                    bus_rd_strobe_i,
  output int                      check_cnt_o,
  output int                      error_cnt_o
);

  typedef enum logic [1:0] {P_OFF, P_START, P_FRAME, P_DATA} phase_e;

  // Host to bus model
  phase_e                  wr_phase;
  int                      wr_bit;        // Bit index in the host byte
  logic [JSP_BYTE_W-1:0]   wr_byte;       // Host byte being assembled
  int                      host_cnt;      // Upper nibble of the count frame
  int                      host_left;
  int                      space_cap;     // Free space seen at capture
  int                      space_left;
  int                      full_bytes;    // Data bytes completed after the frame
  int                      wr_seen;
  logic                    exp_wr;

  // Bus to host model
  logic                    rd_on;
  int                      rd_bit;
  int                      rd_byte_idx;   // 0 is the status byte
  logic [JSP_BYTE_W-1:0]   status_byte;
  logic [JSP_BYTE_W-1:0]   rd_exp;        // Byte popped at the last strobe
  logic                    rd_exp_vld;
  int                      avail_cap;
  int                      avail_left;
  int                      started_bytes; // Data bytes whose first bit went out
  int                      rd_seen;
  logic                    exp_rd;
  logic                    tdo_prev;      // TDO at the last falling edge
  logic                    tdo_moves;     // Last rising edge may change TDO

  initial begin
    check_cnt_o = 0;
    error_cnt_o = 0;
  end

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt_o++;
    if (got !== exp) begin
      error_cnt_o++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic int smaller_of(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  //////////////////////////////
  // Per cycle prediction
  //////////////////////////////

  // Inputs change after the rising edge, so the falling edge sees one whole cycle
  always @(negedge tck_i) begin
    if (rst_i) begin
      wr_phase  = P_OFF;
      rd_on     = 1'b0;
      tdo_prev  = 1'b0;
      tdo_moves = 1'b0;
      compare("write strobe in reset", bus_wr_strobe_i, 0);
      compare("read strobe in reset", bus_rd_strobe_i, 0);
      compare("TDO in reset", module_tdo_i, 0);
    end else begin
      exp_wr = 1'b0;
      exp_rd = 1'b0;

      // Pauses and unselected scans leave TDO where it was
      if (!tdo_moves) compare("TDO hold", module_tdo_i, tdo_prev);

      // Write side, zeros before the start bit are skipped
      if (shift_dr_i) begin
        case (wr_phase)
          P_START: begin
            if (tdi_i) begin
              wr_phase = P_FRAME;  // Start bit itself not stored
              wr_bit   = 0;
            end
          end
          P_FRAME, P_DATA: begin
            wr_byte[wr_bit] = tdi_i;  // LSB first
            if (wr_bit == JSP_BIT_MAX) begin
              if (wr_phase == P_FRAME) begin
                host_cnt  = wr_byte[7:4];
                host_left = host_cnt;
                wr_phase  = P_DATA;
              end else begin
                full_bytes++;
                if (host_left > 0 && space_left > 0) begin
                  exp_wr = 1'b1;
                  host_left--;
                  space_left--;
                end
              end
              wr_bit = 0;
            end else begin
              wr_bit++;
            end
          end
          default: ;
        endcase
      end
      compare("write strobe", bus_wr_strobe_i, exp_wr);
      if (exp_wr) compare("write data", bus_wdata_i, wr_byte);
      if (bus_wr_strobe_i) wr_seen++;

      // Read side, status byte first and then the popped bytes
      if (shift_dr_i && rd_on) begin
        if (rd_byte_idx == 0) begin
          compare("status bit", module_tdo_i, status_byte[rd_bit]);
        end else begin
          if (rd_bit == 0) begin
            started_bytes++;
            rd_exp_vld = (avail_left > 0);
            if (rd_exp_vld) begin
              exp_rd = 1'b1;
              rd_exp = bus_rdata_i;  // Head byte leaves the queue now
              avail_left--;
            end
          end
          if (rd_exp_vld) compare("read data bit", module_tdo_i, rd_exp[rd_bit]);
        end
        if (rd_bit == JSP_BIT_MAX) begin
          rd_bit = 0;
          rd_byte_idx++;
        end else begin
          rd_bit++;
        end
      end
      compare("read strobe", bus_rd_strobe_i, exp_rd);
      if (bus_rd_strobe_i) rd_seen++;

      tdo_prev  = module_tdo_i;
      tdo_moves = shift_dr_i && rd_on;  // Only a shift of a live scan moves TDO

      // Scan boundaries
      if (update_dr_i) begin
        if (rd_on) begin
          compare("write strobe count", wr_seen,
                  smaller_of(smaller_of(host_cnt, space_cap), full_bytes));
          compare("read strobe count", rd_seen, smaller_of(avail_cap, started_bytes));
        end
        wr_phase = P_OFF;
        rd_on    = 1'b0;
      end else if (capture_dr_i && module_select_i && !rd_on) begin
        wr_phase      = JSP_MULTI_CHAIN ? P_START : P_FRAME;
        wr_bit        = 0;
        host_cnt      = 0;
        host_left     = 0;
        space_cap     = bus_free_i;
        space_left    = space_cap;
        full_bytes    = 0;
        wr_seen       = 0;
        rd_on         = 1'b1;
        status_byte   = {bus_avail_i, bus_free_i};  // Avail high, free low
        avail_cap     = bus_avail_i;
        avail_left    = avail_cap;
        rd_bit        = 0;
        rd_byte_idx   = 0;
        rd_exp_vld    = 1'b0;
        started_bytes = 0;
        rd_seen       = 0;
        tdo_moves     = 1'b1;  // Status byte loads at this edge
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_jsp.sv
/*
  JTAG serial port testbench
  Seeded random DR scans through the data path, with the bus
  side modelled as two byte queues
*/

`default_nettype none

module tb_jsp
  import jsp_pkg::*;
();

  localparam int NUM_SCANS   = 40;
  localparam int SCAN_CYCLES = 300;                    // Longest scan with pauses
  localparam int CYCLE_LIMIT = NUM_SCANS * SCAN_CYCLES;

  logic                    tck_i;
  logic                    rst_i;
  logic                    capture_dr;
  logic                    shift_dr;
  logic                    update_dr;
  logic                    module_select;
  logic                    tdi;
  logic [JSP_DR_W-1:0]     data_register;  // Previous seven TDI bits
  logic [JSP_BYTE_W-1:0]   bus_rdata;
  logic [JSP_NIBBLE_W-1:0] bus_avail;
  logic [JSP_NIBBLE_W-1:0] bus_free;
  logic                    module_tdo;
  logic [JSP_BYTE_W-1:0]   bus_wdata;
  logic                    bus_wr_strobe;
  logic                    bus_rd_strobe;
  int                      check_cnt;
  int                      error_cnt;
  int                      cycle_cnt;
  integer                  seed;

  logic [JSP_BYTE_W-1:0]   rd_q[$];        // Bus to host, head on bus_rdata
  logic [JSP_BYTE_W-1:0]   wr_q[$];        // Bytes taken from the host
  logic                    host_bits[$];   // Serial stream for one scan
  logic                    pop_pend;
  logic                    push_pend;
  logic [JSP_BYTE_W-1:0]   push_data;

  jsp_top u_jsp_top (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr),
    .shift_dr_i      (shift_dr),
    .update_dr_i     (update_dr),
    .module_select_i (module_select),
    .tdi_i           (tdi),
    .data_register_i (data_register),
    .module_tdo_o    (module_tdo),
    .bus_rdata_i     (bus_rdata),
    .bus_avail_i     (bus_avail),
    .bus_free_i      (bus_free),
    .bus_wdata_o     (bus_wdata),
    .bus_wr_strobe_o (bus_wr_strobe),
    .bus_rd_strobe_o (bus_rd_strobe)
  );

  jsp_checker u_checker (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr),
    .shift_dr_i      (shift_dr),
    .update_dr_i     (update_dr),
    .module_select_i (module_select),
    .tdi_i           (tdi),
    .bus_rdata_i     (bus_rdata),
    .bus_avail_i     (bus_avail),
    .bus_free_i      (bus_free),
    .module_tdo_i    (module_tdo),
    .bus_wdata_i     (bus_wdata),
    .bus_wr_strobe_i (bus_wr_strobe),
    .bus_rd_strobe_i (bus_rd_strobe),
    .check_cnt_o     (check_cnt),
    .error_cnt_o     (error_cnt)
  );

  initial tck_i = 1'b0;
  always #50 tck_i = ~tck_i;

  // Strobes are settled by the falling edge, applied after the next rise
  always @(negedge tck_i) begin
    pop_pend  = bus_rd_strobe;
    push_pend = bus_wr_strobe;
    push_data = bus_wdata;
  end

  //////////////////////////////
  // Bus side and TAP helpers
  //////////////////////////////

  task automatic drive_bus();
    bus_rdata = (rd_q.size() > 0) ? rd_q[0] : 8'h00;
    bus_avail = JSP_NIBBLE_W'(rd_q.size());
    bus_free  = JSP_NIBBLE_W'(15 - wr_q.size());
  endtask

  // One TCK cycle, new inputs go out 10 units after the edge
  task automatic next_cycle();
    @(posedge tck_i);
    #10;
    if (shift_dr) data_register = {tdi, data_register[JSP_DR_W-1:1]};  // DR shifts right
    if (pop_pend && rd_q.size() > 0) rd_q.delete(0);
    if (push_pend) wr_q.push_back(push_data);
    pop_pend  = 1'b0;
    push_pend = 1'b0;
    drive_bus();
  endtask

  task automatic refill_queues();
    int n;
    n = {$random(seed)} % 16;
    rd_q.delete();
    repeat (n) rd_q.push_back(8'($random(seed)));
    n = {$random(seed)} % (wr_q.size() + 1);  // Bus drains part of its queue
    repeat (n) wr_q.delete(0);
    drive_bus();
  endtask

  // Leading zeros, start bit, count frame, then data bytes
  task automatic build_host_stream();
    int                    lead;
    logic [JSP_BYTE_W-1:0] b;
    host_bits.delete();
    lead = {$random(seed)} % 6;
    repeat (lead) host_bits.push_back(1'b0);
    host_bits.push_back(1'b1);
    for (int k = 0; k < 21; k++) begin
      b = 8'($random(seed));
      for (int i = 0; i < JSP_BYTE_W; i++) host_bits.push_back(b[i]);
    end
  endtask

  task automatic run_scan();
    int n_shift;
    int done;
    refill_queues();
    build_host_stream();
    module_select = ({$random(seed)} % 8) != 0;  // Mostly addressed
    n_shift       = {$random(seed)} % 180;
    capture_dr    = 1'b1;
    next_cycle();
    capture_dr = 1'b0;
    done       = 0;
    while (done < n_shift) begin
      if ({$random(seed)} % 10 == 0) begin
        shift_dr = 1'b0;               // Pause, TDI ignored
        tdi      = 1'($random(seed));
      end else begin
        shift_dr = 1'b1;
        tdi      = (host_bits.size() > 0) ? host_bits.pop_front() : 1'b0;
        done++;
      end
      next_cycle();
    end
    shift_dr  = 1'b0;
    update_dr = 1'b1;
    next_cycle();
    update_dr = 1'b0;
    next_cycle();
  endtask

  //////////////////////////////
  // Sequence and verdict
  //////////////////////////////

  initial begin
    seed          = 32'h2a25f2fd;
    rst_i         = 1'b1;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b0;
    tdi           = 1'b0;
    data_register = '0;
    pop_pend      = 1'b0;
    push_pend     = 1'b0;
    push_data     = '0;
    drive_bus();
    repeat (2) @(posedge tck_i);
    #10;
    rst_i = 1'b0;
    repeat (NUM_SCANS) run_scan();
    repeat (2) next_cycle();
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Cycle budget for all scans
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge tck_i);
      cycle_cnt++;
    end
    $display("Timeout: the scans did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hw/jsp_pkg.sv
hw/jsp_tap_if.sv
hw/jsp_write_ctrl.sv
hw/jsp_read_ctrl.sv
hw/jsp_top.sv
testbench/jsp_checker.sv
testbench/tb_jsp.sv

// File: Bender.yml
package:
  name: jsp

sources:
  - hw/jsp_pkg.sv
  - hw/jsp_tap_if.sv
  - hw/jsp_write_ctrl.sv
  - hw/jsp_read_ctrl.sv
  - hw/jsp_top.sv
  - target: test
    files:
      - testbench/jsp_checker.sv
      - testbench/tb_jsp.sv
